//--- sources.f
source/lce_pkg.sv
source/lce_req_handler.sv
source/lce_cmd_handler.sv
source/lce_resp_arb.sv
source/lce_top.sv
bench/lce_chk.sv
bench/lce_tb.sv

//--- run.sh
#!/bin/sh
# build the LCE testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module lce_tb -f sources.f -o lce_sim

if ! ./obj_dir/lce_sim > sim.log 2>&1; then
  cat sim.log
  echo "simulator exited with an error"
  exit 1
fi
cat sim.log

if grep -q ">>> FAIL" sim.log; then
  exit 1
fi

//--- bench/lce_tb.sv
/*
 * testbench for the LCE miss engine: scenario table applied in a loop,
 * a small directory model that answers each request, and a compare task
 */
`timescale 1ns/1ps

module lce_tb;

  localparam int num_cce = 4;
  localparam int timeout_limit = 4;
  localparam int wait_max = 50;
  localparam logic [3:0] my_id = 4'd5;

  // how the directory model answers a request
  localparam int seq_tag_data = 0;
  localparam int seq_data_tag = 1;
  localparam int seq_none = 2;
  localparam int seq_uc_data = 3;
  localparam int seq_wakeup = 4;
  localparam int seq_inv_blocked = 5;

  typedef struct {
    string name;
    lce_pkg::cache_req_type_e req_type;
    logic [31:0] addr;
    logic [1:0] size;
    logic [63:0] data;
    logic [2:0] way;
    logic dirty;
    int seq;
    logic late_meta;
    logic stalls;
    lce_pkg::lce_req_type_e exp_type;
    logic exp_ack;
  } scenario_t;

  logic clk_i;
  logic reset_i;
  logic [3:0] lce_id_i;
  logic cache_req_v_i, cache_req_metadata_v_i, cache_req_dirty_i;
  lce_pkg::cache_req_type_e cache_req_type_i;
  logic [31:0] cache_req_addr_i;
  logic [1:0] cache_req_size_i;
  logic [63:0] cache_req_data_i;
  logic [2:0] cache_req_way_i;
  logic cache_req_ready_o, cache_req_complete_o;
  logic [31:0] miss_addr_o;
  logic dcache_free_i;
  logic lce_req_ready_i, lce_req_v_o, lce_req_lru_dirty_o;
  lce_pkg::lce_req_type_e lce_req_type_o;
  logic [31:0] lce_req_addr_o;
  logic [3:0] lce_req_dst_o, lce_req_src_o;
  logic [1:0] lce_req_size_o;
  logic [63:0] lce_req_data_o;
  logic [2:0] lce_req_lru_way_o;
  logic lce_cmd_v_i, lce_cmd_ready_o;
  lce_pkg::lce_cmd_type_e lce_cmd_type_i;
  logic [31:0] lce_cmd_addr_i;
  logic [2:0] lce_cmd_way_i;
  logic [63:0] lce_cmd_payload_i;
  logic lce_resp_yumi_i, lce_resp_v_o;
  lce_pkg::lce_resp_type_e lce_resp_type_o;
  logic [31:0] lce_resp_addr_o;
  logic [3:0] lce_resp_dst_o, lce_resp_src_o;
  logic tag_mem_v_o, data_mem_v_o, uc_data_v_o;
  logic [31:0] tag_mem_addr_o;
  logic [2:0] tag_mem_way_o, data_mem_way_o;
  logic [19:0] tag_mem_tag_o;
  lce_pkg::coh_state_e tag_mem_state_o;
  logic [63:0] data_mem_data_o, uc_data_o;

  integer seed;
  int err_cnt;
  int fail_cnt;
  logic stall_en;
  string cur_name;
  scenario_t tbl[6];

  lce_top #(
    .num_cce_p(num_cce),
    .timeout_max_limit_p(timeout_limit)
  ) lce_top_inst (.*);

  always #4 clk_i = ~clk_i;

  // 64 byte blocks spread over four directories by the low block bits
  function automatic logic [3:0] dir_of_addr(logic [31:0] addr);
    return {2'b00, addr[7:6]};
  endfunction

  task automatic check(string what, logic [63:0] exp, logic [63:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", cur_name, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic report_timeout(string what);
    $display("test %s: timed out waiting for %s", cur_name, what);
    err_cnt++;
  endtask

  // directory side refuses requests now and then
  task automatic next_cycle();
    @(negedge clk_i);
    lce_req_ready_i = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
  endtask

  task automatic check_request(scenario_t r);
    check("req valid", 1, lce_req_v_o);
    check("req type", r.exp_type, lce_req_type_o);
    check("req addr", r.addr, lce_req_addr_o);
    check("req src", my_id, lce_req_src_o);
    check("req dst", dir_of_addr(r.addr), lce_req_dst_o);
    if (r.exp_type == lce_pkg::uc_wr || r.exp_type == lce_pkg::uc_rd) begin
      check("req size", r.size, lce_req_size_o);
    end else begin
      check("lru way", r.way, lce_req_lru_way_o);
      check("lru dirty", r.dirty, lce_req_lru_dirty_o);
    end
    if (r.exp_type == lce_pkg::uc_wr) begin
      check("req data", r.data, lce_req_data_o);
    end
  endtask

  task automatic send_request(scenario_t r);
    int n;
    next_cycle();
    cache_req_v_i = 1'b1;
    cache_req_type_i = r.req_type;
    cache_req_addr_i = r.addr;
    cache_req_size_i = r.size;
    cache_req_data_i = r.data;
    cache_req_metadata_v_i = ~r.late_meta;
    cache_req_way_i = r.late_meta ? ~r.way : r.way;
    cache_req_dirty_i = r.late_meta ? ~r.dirty : r.dirty;
    #1;
    n = 0;
    while (!cache_req_ready_o && n < wait_max) begin
      next_cycle();
      #1;
      n++;
    end
    if (n == wait_max) begin
      report_timeout("cache request ready");
    end else if (r.req_type == lce_pkg::uc_store) begin
      // the uncached store leaves in its acceptance cycle
      check("complete", 1, cache_req_complete_o);
      check_request(r);
    end
    next_cycle();
    cache_req_v_i = 1'b0;
    cache_req_metadata_v_i = 1'b0;
    #1;
  endtask

  task automatic wait_request(scenario_t r);
    int n;
    logic meta_sent;
    meta_sent = ~r.late_meta;
    n = 0;
    while (!lce_req_v_o && n < wait_max) begin
      next_cycle();
      // late metadata shows up a few cycles after acceptance
      cache_req_metadata_v_i = r.late_meta && n == 3;
      cache_req_way_i = cache_req_metadata_v_i ? r.way : ~r.way;
      cache_req_dirty_i = cache_req_metadata_v_i ? r.dirty : ~r.dirty;
      meta_sent = meta_sent | cache_req_metadata_v_i;
      #1;
      if (lce_req_v_o && !meta_sent) begin
        $display("test %s: request sent before its metadata", cur_name);
        err_cnt++;
      end
      n++;
    end
    if (n == wait_max) begin
      report_timeout("directory request");
    end else begin
      check_request(r);
      check("miss addr", r.addr, miss_addr_o);
    end
    next_cycle();
    cache_req_metadata_v_i = 1'b0;
    #1;
    check("req valid after send", 0, lce_req_v_o);
  endtask

  task automatic check_write(lce_pkg::lce_cmd_type_e t, logic [31:0] addr, logic [2:0] way,
                             logic [63:0] payload);
    int n;
    n = 0;
    while (!(tag_mem_v_o || data_mem_v_o || uc_data_v_o) && n < wait_max) begin
      next_cycle();
      #1;
      n++;
    end
    if (n == wait_max) begin
      report_timeout("memory write");
    end else if (t == lce_pkg::data) begin
      check("data write", 1, data_mem_v_o);
      check("data way", way, data_mem_way_o);
      check("data word", payload, data_mem_data_o);
    end else if (t == lce_pkg::uc_data) begin
      check("uc data valid", 1, uc_data_v_o);
      check("uc data", payload, uc_data_o);
    end else begin
      check("tag write", 1, tag_mem_v_o);
      check("tag addr", addr, tag_mem_addr_o);
      check("tag way", way, tag_mem_way_o);
      if (t == lce_pkg::invalidate) begin
        check("inv state", lce_pkg::invalid, tag_mem_state_o);
      end else begin
        check("tag", addr[31:12], tag_mem_tag_o);
        check("tag state", lce_pkg::exclusive, tag_mem_state_o);
      end
    end
  endtask

  task automatic deliver(lce_pkg::lce_cmd_type_e t, logic [31:0] addr, logic [2:0] way,
                         logic [63:0] payload);
    int n;
    next_cycle();
    lce_cmd_v_i = 1'b1;
    lce_cmd_type_i = t;
    lce_cmd_addr_i = addr;
    lce_cmd_way_i = way;
    lce_cmd_payload_i = payload;
    #1;
    n = 0;
    while (!lce_cmd_ready_o && n < wait_max) begin
      next_cycle();
      #1;
      n++;
    end
    if (n == wait_max) begin
      report_timeout("command ready");
    end
    next_cycle();
    lce_cmd_v_i = 1'b0;
    #1;
    if (dcache_free_i) begin
      check_write(t, addr, way, payload);
    end
  endtask

  task automatic take_response(lce_pkg::lce_resp_type_e t, logic [31:0] addr);
    int n;
    n = 0;
    while (!lce_resp_v_o && n < wait_max) begin
      next_cycle();
      #1;
      n++;
    end
    if (n == wait_max) begin
      report_timeout("response valid");
    end else begin
      check("resp type", t, lce_resp_type_o);
      check("resp addr", addr, lce_resp_addr_o);
      check("resp dst", dir_of_addr(addr), lce_resp_dst_o);
      check("resp src", my_id, lce_resp_src_o);
    end
    next_cycle();
    lce_resp_yumi_i = lce_resp_v_o;
    #1;
    next_cycle();
    lce_resp_yumi_i = 1'b0;
    #1;
  endtask

  task automatic expect_no_response();
    repeat (3) begin
      next_cycle();
      #1;
      check("no response", 0, lce_resp_v_o);
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!cache_req_ready_o && n < wait_max) begin
      next_cycle();
      #1;
      n++;
    end
    if (n == wait_max) begin
      report_timeout("cache request ready after the miss");
    end
  endtask

  task automatic run_scenario(scenario_t r);
    logic [63:0] tag_word;
    cur_name = r.name;
    err_cnt = 0;
    stall_en = r.stalls;
    tag_word = {42'b0, lce_pkg::exclusive, r.addr[31:12]};
    if (r.seq == seq_inv_blocked) begin
      next_cycle();
      dcache_free_i = 1'b0;
      #1;
      deliver(lce_pkg::invalidate, r.addr, r.way, r.data);
      // held command starves the memories past the timeout limit
      repeat (timeout_limit + 3) begin
        next_cycle();
        #1;
        check("ready while blocked", 0, cache_req_ready_o);
        check("write while blocked", 0, tag_mem_v_o);
      end
      next_cycle();
      dcache_free_i = 1'b1;
      #1;
      check_write(lce_pkg::invalidate, r.addr, r.way, r.data);
      take_response(lce_pkg::inv_ack, r.addr);
    end else begin
      send_request(r);
      if (r.seq != seq_none) begin
        wait_request(r);
      end
      case (r.seq)
        seq_tag_data: begin
          deliver(lce_pkg::set_tag, r.addr, r.way, tag_word);
          deliver(lce_pkg::data, r.addr, r.way, r.data);
        end
        seq_data_tag: begin
          deliver(lce_pkg::data, r.addr, r.way, r.data);
          deliver(lce_pkg::set_tag, r.addr, r.way, tag_word);
        end
        seq_uc_data: deliver(lce_pkg::uc_data, r.addr, r.way, r.data);
        seq_wakeup: deliver(lce_pkg::set_tag_wakeup, r.addr, r.way, tag_word);
        default: ;
      endcase
      if (r.exp_ack) begin
        take_response(lce_pkg::coh_ack, r.addr);
      end else begin
        expect_no_response();
      end
    end
    wait_idle();
  endtask

  initial begin
    seed = 64;
    fail_cnt = 0;
    stall_en = 1'b0;
    clk_i = 1'b0;
    reset_i = 1'b1;
    lce_id_i = my_id;
    cache_req_v_i = 1'b0;
    cache_req_type_i = lce_pkg::miss_load;
    cache_req_addr_i = '0;
    cache_req_size_i = '0;
    cache_req_data_i = '0;
    cache_req_metadata_v_i = 1'b0;
    cache_req_way_i = '0;
    cache_req_dirty_i = 1'b0;
    dcache_free_i = 1'b1;
    lce_req_ready_i = 1'b1;
    lce_cmd_v_i = 1'b0;
    lce_cmd_type_i = lce_pkg::set_tag;
    lce_cmd_addr_i = '0;
    lce_cmd_way_i = '0;
    lce_cmd_payload_i = '0;
    lce_resp_yumi_i = 1'b0;

    tbl[0] = '{"load_miss", lce_pkg::miss_load, 32'h8001_2340, 2'd3, 64'h0123_4567_89ab_cdef,
               3'd5, 1'b1, seq_tag_data, 1'b0, 1'b1, lce_pkg::rd, 1'b1};
    tbl[1] = '{"store_late_meta", lce_pkg::miss_store, 32'h0004_56c0, 2'd3,
               64'hfeed_face_0bad_f00d, 3'd2, 1'b0, seq_data_tag, 1'b1, 1'b1, lce_pkg::wr, 1'b1};
    tbl[2] = '{"uc_store", lce_pkg::uc_store, 32'h1000_0084, 2'd2, 64'h0000_0000_dead_beef,
               3'd0, 1'b0, seq_none, 1'b0, 1'b1, lce_pkg::uc_wr, 1'b0};
    tbl[3] = '{"uc_load", lce_pkg::uc_load, 32'h1000_0100, 2'd1, 64'h5a5a_a5a5_1234_8765,
               3'd0, 1'b0, seq_uc_data, 1'b0, 1'b1, lce_pkg::uc_rd, 1'b0};
    tbl[4] = '{"wakeup", lce_pkg::miss_load, 32'h0007_8fc0, 2'd3, 64'h0,
               3'd7, 1'b1, seq_wakeup, 1'b0, 1'b1, lce_pkg::rd, 1'b1};
    tbl[5] = '{"inv_blocked", lce_pkg::miss_load, 32'h0003_3040, 2'd0, 64'h0,
               3'd4, 1'b0, seq_inv_blocked, 1'b0, 1'b0, lce_pkg::rd, 1'b0};

    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    foreach (tbl[i]) begin
      run_scenario(tbl[i]);
      if (err_cnt == 0) begin
        $display("test %s: passed", tbl[i].name);
      end else begin
        $display("test %s: failed with %0d errors", tbl[i].name, err_cnt);
        fail_cnt++;
      end
    end

    $display("tests run %0d, passed %0d, failed %0d", $size(tbl), $size(tbl) - fail_cnt,
             fail_cnt);
    if (fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- bench/lce_chk.sv
/*
 * assertions bound into lce_top: one received pulse per cycle,
 * request valid only with ready, held responses stable until yumi
 */
`timescale 1ns/1ps

module lce_chk (
  input  logic clk_i,
  input  logic reset_i,
  input  logic set_tag_received_i,
  input  logic set_tag_wakeup_received_i,
  input  logic data_received_i,
  input  logic uc_data_received_i,
  input  logic req_v_i,
  input  logic req_ready_i,
  input  logic resp_v_i,
  input  logic resp_yumi_i,
  input  lce_pkg::lce_resp_type_e resp_type_i,
  input  logic [lce_pkg::paddr_width-1:0] resp_addr_i,
  input  logic [lce_pkg::cce_id_width-1:0] resp_dst_i
);

  one_pulse_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({set_tag_received_i, set_tag_wakeup_received_i, data_received_i,
              uc_data_received_i}))
    else $error("more than one received pulse in a cycle");

  req_ready_a: assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_i |-> req_ready_i)
    else $error("request valid raised without ready");

  // a response waits unchanged for its yumi
  resp_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_i && !resp_yumi_i |=> resp_v_i && $stable(resp_type_i) &&
      $stable(resp_addr_i) && $stable(resp_dst_i))
    else $error("response changed before yumi");

endmodule

bind lce_top lce_chk chk_inst (
  .clk_i(clk_i),
  .reset_i(reset_i),
  .set_tag_received_i(set_tag_received),
  .set_tag_wakeup_received_i(set_tag_wakeup_received),
  .data_received_i(data_received),
  .uc_data_received_i(uc_data_received),
  .req_v_i(lce_req_v_o),
  .req_ready_i(lce_req_ready_i),
  .resp_v_i(lce_resp_v_o),
  .resp_yumi_i(lce_resp_yumi_i),
  .resp_type_i(lce_resp_type_o),
  .resp_addr_i(lce_resp_addr_o),
  .resp_dst_i(lce_resp_dst_o)
);

//--- source/lce_top.sv
/*
 * LCE miss engine top: request FSM, command handler and response merge
 */
`timescale 1ns/1ps

module lce_top #(
  parameter int num_cce_p = 4,
  parameter int timeout_max_limit_p = 4
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic [lce_pkg::lce_id_width-1:0] lce_id_i,

  // cache side
  input  logic cache_req_v_i,
  input  lce_pkg::cache_req_type_e cache_req_type_i,
  input  logic [lce_pkg::paddr_width-1:0] cache_req_addr_i,
  input  logic [lce_pkg::uc_size_width-1:0] cache_req_size_i,
  input  logic [lce_pkg::dword_width-1:0] cache_req_data_i,
  input  logic cache_req_metadata_v_i,
  input  logic [lce_pkg::way_width-1:0] cache_req_way_i,
  input  logic cache_req_dirty_i,
  output logic cache_req_ready_o,
  output logic cache_req_complete_o,
  output logic [lce_pkg::paddr_width-1:0] miss_addr_o,
  input  logic dcache_free_i,

  // request network
  input  logic lce_req_ready_i,
  output logic lce_req_v_o,
  output lce_pkg::lce_req_type_e lce_req_type_o,
  output logic [lce_pkg::paddr_width-1:0] lce_req_addr_o,
  output logic [lce_pkg::cce_id_width-1:0] lce_req_dst_o,
  output logic [lce_pkg::lce_id_width-1:0] lce_req_src_o,
  output logic [lce_pkg::uc_size_width-1:0] lce_req_size_o,
  output logic [lce_pkg::dword_width-1:0] lce_req_data_o,
  output logic [lce_pkg::way_width-1:0] lce_req_lru_way_o,
  output logic lce_req_lru_dirty_o,

  // command network
  input  logic lce_cmd_v_i,
  input  lce_pkg::lce_cmd_type_e lce_cmd_type_i,
  input  logic [lce_pkg::paddr_width-1:0] lce_cmd_addr_i,
  input  logic [lce_pkg::way_width-1:0] lce_cmd_way_i,
  input  logic [lce_pkg::dword_width-1:0] lce_cmd_payload_i,
  output logic lce_cmd_ready_o,

  // response network
  input  logic lce_resp_yumi_i,
  output logic lce_resp_v_o,
  output lce_pkg::lce_resp_type_e lce_resp_type_o,
  output logic [lce_pkg::paddr_width-1:0] lce_resp_addr_o,
  output logic [lce_pkg::cce_id_width-1:0] lce_resp_dst_o,
  output logic [lce_pkg::lce_id_width-1:0] lce_resp_src_o,

  // memory write strobes
  output logic tag_mem_v_o,
  output logic [lce_pkg::paddr_width-1:0] tag_mem_addr_o,
  output logic [lce_pkg::way_width-1:0] tag_mem_way_o,
  output logic [lce_pkg::tag_width-1:0] tag_mem_tag_o,
  output lce_pkg::coh_state_e tag_mem_state_o,
  output logic data_mem_v_o,
  output logic [lce_pkg::way_width-1:0] data_mem_way_o,
  output logic [lce_pkg::dword_width-1:0] data_mem_data_o,
  output logic uc_data_v_o,
  output logic [lce_pkg::dword_width-1:0] uc_data_o
);

  logic cmd_ready;
  logic coherence_blocked;
  logic set_tag_received;
  logic set_tag_wakeup_received;
  logic data_received;
  logic uc_data_received;

  logic ack_v;
  logic ack_yumi;
  logic [lce_pkg::paddr_width-1:0] ack_addr;
  logic [lce_pkg::cce_id_width-1:0] ack_dst;
  logic inv_v;
  logic inv_yumi;
  logic [lce_pkg::paddr_width-1:0] inv_addr;
  logic [lce_pkg::cce_id_width-1:0] inv_dst;

  lce_req_handler #(
    .num_cce_p(num_cce_p),
    .timeout_max_limit_p(timeout_max_limit_p)
  ) req_handler_inst (
    .clk_i, .reset_i, .lce_id_i,
    .cache_req_v_i, .cache_req_type_i, .cache_req_addr_i, .cache_req_size_i,
    .cache_req_data_i, .cache_req_metadata_v_i, .cache_req_way_i, .cache_req_dirty_i,
    .cache_req_ready_o, .cache_req_complete_o, .miss_addr_o,
    .cmd_ready_i(cmd_ready),
    .coherence_blocked_i(coherence_blocked),
    .set_tag_received_i(set_tag_received),
    .set_tag_wakeup_received_i(set_tag_wakeup_received),
    .data_received_i(data_received),
    .uc_data_received_i(uc_data_received),
    .lce_req_ready_i, .lce_req_v_o, .lce_req_type_o, .lce_req_addr_o, .lce_req_dst_o,
    .lce_req_src_o, .lce_req_size_o, .lce_req_data_o, .lce_req_lru_way_o,
    .lce_req_lru_dirty_o,
    .resp_yumi_i(ack_yumi),
    .resp_v_o(ack_v),
    .resp_addr_o(ack_addr),
    .resp_dst_o(ack_dst)
  );

  lce_cmd_handler #(
    .num_cce_p(num_cce_p)
  ) cmd_handler_inst (
    .clk_i, .reset_i,
    .lce_cmd_v_i, .lce_cmd_type_i, .lce_cmd_addr_i, .lce_cmd_way_i, .lce_cmd_payload_i,
    .lce_cmd_ready_o, .dcache_free_i,
    .cmd_ready_o(cmd_ready),
    .coherence_blocked_o(coherence_blocked),
    .set_tag_received_o(set_tag_received),
    .set_tag_wakeup_received_o(set_tag_wakeup_received),
    .data_received_o(data_received),
    .uc_data_received_o(uc_data_received),
    .tag_mem_v_o, .tag_mem_addr_o, .tag_mem_way_o, .tag_mem_tag_o, .tag_mem_state_o,
    .data_mem_v_o, .data_mem_way_o, .data_mem_data_o, .uc_data_v_o, .uc_data_o,
    .inv_yumi_i(inv_yumi),
    .inv_v_o(inv_v),
    .inv_addr_o(inv_addr),
    .inv_dst_o(inv_dst)
  );

  lce_resp_arb resp_arb_inst (
    .inv_v_i(inv_v), .inv_addr_i(inv_addr), .inv_dst_i(inv_dst),
    .ack_v_i(ack_v), .ack_addr_i(ack_addr), .ack_dst_i(ack_dst),
    .lce_id_i, .lce_resp_yumi_i,
    .lce_resp_v_o, .lce_resp_type_o, .lce_resp_addr_o, .lce_resp_dst_o, .lce_resp_src_o,
    .inv_yumi_o(inv_yumi),
    .ack_yumi_o(ack_yumi)
  );

endmodule

//--- source/lce_resp_arb.sv
/*
 * fixed priority response merge, invalidate ack ahead of coherence ack
 */
`timescale 1ns/1ps

module lce_resp_arb (
  input  logic inv_v_i,
  input  logic [lce_pkg::paddr_width-1:0] inv_addr_i,
  input  logic [lce_pkg::cce_id_width-1:0] inv_dst_i,
  input  logic ack_v_i,
  input  logic [lce_pkg::paddr_width-1:0] ack_addr_i,
  input  logic [lce_pkg::cce_id_width-1:0] ack_dst_i,
  input  logic [lce_pkg::lce_id_width-1:0] lce_id_i,

  input  logic lce_resp_yumi_i,
  output logic lce_resp_v_o,
  output lce_pkg::lce_resp_type_e lce_resp_type_o,
  output logic [lce_pkg::paddr_width-1:0] lce_resp_addr_o,
  output logic [lce_pkg::cce_id_width-1:0] lce_resp_dst_o,
  output logic [lce_pkg::lce_id_width-1:0] lce_resp_src_o,
  output logic inv_yumi_o,
  output logic ack_yumi_o
);

  assign lce_resp_v_o = inv_v_i | ack_v_i;
  assign lce_resp_type_o = inv_v_i ? lce_pkg::inv_ack : lce_pkg::coh_ack;
  assign lce_resp_addr_o = inv_v_i ? inv_addr_i : ack_addr_i;
  assign lce_resp_dst_o = inv_v_i ? inv_dst_i : ack_dst_i;
  assign lce_resp_src_o = lce_id_i;

  // yumi only goes back to the source that was forwarded
  assign inv_yumi_o = inv_v_i & lce_resp_yumi_i;
  assign ack_yumi_o = ~inv_v_i & ack_v_i & lce_resp_yumi_i;

endmodule

//--- source/lce_cmd_handler.sv
/*
 * directory command handler: holds one command, writes tag and data
 * memories when free, signals the request FSM and sends invalidate acks
 */
`timescale 1ns/1ps

module lce_cmd_handler #(
  parameter int num_cce_p = 4
) (
  input  logic clk_i,
  input  logic reset_i,

  input  logic lce_cmd_v_i,
  input  lce_pkg::lce_cmd_type_e lce_cmd_type_i,
  input  logic [lce_pkg::paddr_width-1:0] lce_cmd_addr_i,
  input  logic [lce_pkg::way_width-1:0] lce_cmd_way_i,
  input  logic [lce_pkg::dword_width-1:0] lce_cmd_payload_i,
  output logic lce_cmd_ready_o,

  input  logic dcache_free_i,
  output logic cmd_ready_o,
  output logic coherence_blocked_o,
  output logic set_tag_received_o,
  output logic set_tag_wakeup_received_o,
  output logic data_received_o,
  output logic uc_data_received_o,

  output logic tag_mem_v_o,
  output logic [lce_pkg::paddr_width-1:0] tag_mem_addr_o,
  output logic [lce_pkg::way_width-1:0] tag_mem_way_o,
  output logic [lce_pkg::tag_width-1:0] tag_mem_tag_o,
  output lce_pkg::coh_state_e tag_mem_state_o,
  output logic data_mem_v_o,
  output logic [lce_pkg::way_width-1:0] data_mem_way_o,
  output logic [lce_pkg::dword_width-1:0] data_mem_data_o,
  output logic uc_data_v_o,
  output logic [lce_pkg::dword_width-1:0] uc_data_o,

  input  logic inv_yumi_i,
  output logic inv_v_o,
  output logic [lce_pkg::paddr_width-1:0] inv_addr_o,
  output logic [lce_pkg::cce_id_width-1:0] inv_dst_o
);

  logic cmd_v_r;
  logic inv_v_r;
  logic write_fire;
  logic is_inv;

  lce_pkg::lce_cmd_type_e type_r;
  logic [lce_pkg::paddr_width-1:0] addr_r;
  logic [lce_pkg::way_width-1:0] way_r;
  lce_pkg::lce_cmd_payload_u payload_r;

  assign lce_cmd_ready_o = ~cmd_v_r;
  assign cmd_ready_o = ~cmd_v_r;
  // an invalidate waiting on its ack no longer needs the memories
  assign coherence_blocked_o = cmd_v_r & ~inv_v_r & ~dcache_free_i;
  assign write_fire = cmd_v_r & ~inv_v_r & dcache_free_i;
  assign is_inv = (type_r == lce_pkg::invalidate);

  assign set_tag_received_o = write_fire & (type_r == lce_pkg::set_tag);
  assign set_tag_wakeup_received_o = write_fire & (type_r == lce_pkg::set_tag_wakeup);
  assign data_received_o = write_fire & (type_r == lce_pkg::data);
  assign uc_data_received_o = write_fire & (type_r == lce_pkg::uc_data);

  assign tag_mem_v_o = set_tag_received_o | set_tag_wakeup_received_o | (write_fire & is_inv);
  assign tag_mem_addr_o = addr_r;
  assign tag_mem_way_o = way_r;
  assign tag_mem_tag_o = payload_r.tag_info.tag;
  assign tag_mem_state_o = is_inv ? lce_pkg::invalid : payload_r.tag_info.state;

  assign data_mem_v_o = data_received_o;
  assign data_mem_way_o = way_r;
  assign data_mem_data_o = payload_r.data_word;
  assign uc_data_v_o = uc_data_received_o;
  assign uc_data_o = payload_r.data_word;

  assign inv_v_o = inv_v_r;
  assign inv_addr_o = addr_r;
  assign inv_dst_o = lce_pkg::cce_id_of(addr_r, num_cce_p);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cmd_v_r <= 1'b0;
      inv_v_r <= 1'b0;
    end else if (!cmd_v_r) begin
      cmd_v_r <= lce_cmd_v_i;
    end else if (write_fire) begin
      // invalidate stays held until its ack is taken
      inv_v_r <= is_inv;
      cmd_v_r <= is_inv;
    end else if (inv_v_r && inv_yumi_i) begin
      inv_v_r <= 1'b0;
      cmd_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lce_cmd_v_i && lce_cmd_ready_o) begin
      type_r <= lce_cmd_type_i;
      addr_r <= lce_cmd_addr_i;
      way_r <= lce_cmd_way_i;
      payload_r <= lce_cmd_payload_i;
    end
  end

endmodule

//--- source/lce_req_handler.sv
/*
 * miss request FSM of the LCE: turns cache misses into directory requests,
 * tracks fill completion and sends the coherence ack,
 * plus metadata bypass register and memory starvation timeout
 */
`timescale 1ns/1ps

module lce_req_handler #(
  parameter int num_cce_p = 4,
  parameter int timeout_max_limit_p = 4
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic [lce_pkg::lce_id_width-1:0] lce_id_i,

  input  logic cache_req_v_i,
  input  lce_pkg::cache_req_type_e cache_req_type_i,
  input  logic [lce_pkg::paddr_width-1:0] cache_req_addr_i,
  input  logic [lce_pkg::uc_size_width-1:0] cache_req_size_i,
  input  logic [lce_pkg::dword_width-1:0] cache_req_data_i,
  input  logic cache_req_metadata_v_i,
  input  logic [lce_pkg::way_width-1:0] cache_req_way_i,
  input  logic cache_req_dirty_i,
  output logic cache_req_ready_o,
  output logic cache_req_complete_o,
  output logic [lce_pkg::paddr_width-1:0] miss_addr_o,

  input  logic cmd_ready_i,
  input  logic coherence_blocked_i,
  input  logic set_tag_received_i,
  input  logic set_tag_wakeup_received_i,
  input  logic data_received_i,
  input  logic uc_data_received_i,

  input  logic lce_req_ready_i,
  output logic lce_req_v_o,
  output lce_pkg::lce_req_type_e lce_req_type_o,
  output logic [lce_pkg::paddr_width-1:0] lce_req_addr_o,
  output logic [lce_pkg::cce_id_width-1:0] lce_req_dst_o,
  output logic [lce_pkg::lce_id_width-1:0] lce_req_src_o,
  output logic [lce_pkg::uc_size_width-1:0] lce_req_size_o,
  output logic [lce_pkg::dword_width-1:0] lce_req_data_o,
  output logic [lce_pkg::way_width-1:0] lce_req_lru_way_o,
  output logic lce_req_lru_dirty_o,

  input  logic resp_yumi_i,
  output logic resp_v_o,
  output logic [lce_pkg::paddr_width-1:0] resp_addr_o,
  output logic [lce_pkg::cce_id_width-1:0] resp_dst_o
);

  localparam int cnt_width = $clog2(timeout_max_limit_p + 1);

  enum logic [2:0] {
    st_ready,
    st_send_cached,
    st_send_uc_load,
    st_sleep,
    st_send_ack
  } state_r, state_n;

  logic accept;
  logic timeout;
  logic [cnt_width-1:0] timeout_cnt_r;

  logic [lce_pkg::paddr_width-1:0] miss_addr_r;
  logic load_not_store_r;
  logic [lce_pkg::uc_size_width-1:0] size_r;

  logic meta_en;
  logic meta_v_r;
  logic meta_v;
  logic [lce_pkg::way_width-1:0] meta_way_r;
  logic meta_dirty_r;

  logic tag_seen_r;
  logic data_seen_r;
  logic tag_seen;
  logic data_seen;

  assign accept = cache_req_v_i & cache_req_ready_o;
  assign cache_req_ready_o = (state_r == st_ready) & lce_req_ready_i & cmd_ready_i & ~timeout;
  assign miss_addr_o = miss_addr_r;

  // metadata may come with the request or any cycle after it
  assign meta_en = accept | cache_req_metadata_v_i;
  assign meta_v = meta_en ? cache_req_metadata_v_i : meta_v_r;
  assign lce_req_lru_way_o = cache_req_metadata_v_i ? cache_req_way_i : meta_way_r;
  assign lce_req_lru_dirty_o = cache_req_metadata_v_i ? cache_req_dirty_i : meta_dirty_r;

  // set_tag and data can land in either order while asleep
  assign tag_seen = tag_seen_r | set_tag_received_i;
  assign data_seen = data_seen_r | data_received_i;

  assign lce_req_src_o = lce_id_i;
  assign lce_req_dst_o = lce_pkg::cce_id_of(lce_req_addr_o, num_cce_p);
  assign resp_addr_o = miss_addr_r;
  assign resp_dst_o = lce_pkg::cce_id_of(miss_addr_r, num_cce_p);

  always_comb begin
    state_n = state_r;
    lce_req_v_o = 1'b0;
    lce_req_type_o = load_not_store_r ? lce_pkg::rd : lce_pkg::wr;
    lce_req_addr_o = miss_addr_r;
    lce_req_size_o = size_r;
    lce_req_data_o = '0;
    cache_req_complete_o = 1'b0;
    resp_v_o = 1'b0;

    case (state_r)
      st_ready: begin
        if (accept) begin
          if (cache_req_type_i == lce_pkg::uc_store) begin
            // uncached store goes out directly, nothing to wait for
            lce_req_v_o = 1'b1;
            lce_req_type_o = lce_pkg::uc_wr;
            lce_req_addr_o = cache_req_addr_i;
            lce_req_size_o = cache_req_size_i;
            lce_req_data_o = cache_req_data_i;
            cache_req_complete_o = 1'b1;
          end else if (cache_req_type_i == lce_pkg::uc_load) begin
            state_n = st_send_uc_load;
          end else begin
            state_n = st_send_cached;
          end
        end
      end

      st_send_cached: begin
        lce_req_v_o = lce_req_ready_i & meta_v;
        if (lce_req_v_o) begin
          state_n = st_sleep;
        end
      end

      st_send_uc_load: begin
        lce_req_v_o = lce_req_ready_i & meta_v;
        lce_req_type_o = lce_pkg::uc_rd;
        if (lce_req_v_o) begin
          state_n = st_sleep;
        end
      end

      st_sleep: begin
        if (set_tag_wakeup_received_i) begin
          state_n = st_send_ack;
        end else if (uc_data_received_i) begin
          state_n = st_ready;
        end else if (tag_seen & data_seen) begin
          state_n = st_send_ack;
        end
      end

      st_send_ack: begin
        resp_v_o = 1'b1;
        if (resp_yumi_i) begin
          state_n = st_ready;
        end
      end

      default: begin
        state_n = st_ready;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= st_ready;
      meta_v_r <= 1'b0;
      tag_seen_r <= 1'b0;
      data_seen_r <= 1'b0;
    end else begin
      state_r <= state_n;
      if (meta_en) begin
        meta_v_r <= cache_req_metadata_v_i;
      end
      if (accept) begin
        tag_seen_r <= 1'b0;
        data_seen_r <= 1'b0;
      end else if (state_r == st_sleep) begin
        tag_seen_r <= tag_seen;
        data_seen_r <= data_seen;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      miss_addr_r <= cache_req_addr_i;
      load_not_store_r <= (cache_req_type_i == lce_pkg::miss_load);
      size_r <= cache_req_size_i;
    end
    if (cache_req_metadata_v_i) begin
      meta_way_r <= cache_req_way_i;
      meta_dirty_r <= cache_req_dirty_i;
    end
  end

  // consecutive cycles a held command has waited on the memories
  always_ff @(posedge clk_i) begin
    if (reset_i || !coherence_blocked_i) begin
      timeout_cnt_r <= '0;
    end else if (!timeout) begin
      timeout_cnt_r <= timeout_cnt_r + 1'b1;
    end
  end

  // stalls the cache to free a memory slot for the command
  assign timeout = (timeout_cnt_r == cnt_width'(timeout_max_limit_p));

endmodule

//--- source/lce_pkg.sv
/*
 * shared widths and message type encodings for the LCE miss engine,
 * the command payload union and the address to directory mapping
 */
package lce_pkg;

  localparam int paddr_width = 32;
  localparam int dword_width = 64;
  localparam int way_width = 3;
  localparam int block_offset_width = 6;
  localparam int tag_width = 20;
  localparam int lce_id_width = 4;
  localparam int cce_id_width = 4;
  // uncached access size, log2 of the byte count
  localparam int uc_size_width = 2;

  typedef enum logic [1:0] {miss_load, miss_store, uc_load, uc_store} cache_req_type_e;

  typedef enum logic [1:0] {rd, wr, uc_rd, uc_wr} lce_req_type_e;

  typedef enum logic [2:0] {
    set_tag,
    set_tag_wakeup,
    data,
    uc_data,
    invalidate
  } lce_cmd_type_e;

  typedef enum logic {coh_ack, inv_ack} lce_resp_type_e;

  typedef enum logic [1:0] {invalid, shared, exclusive} coh_state_e;

  // data and uc_data use the whole word, set_tag packs tag and state at the bottom
  typedef union packed {
    logic [dword_width-1:0] data_word;
    struct packed {
      logic [dword_width-tag_width-3:0] pad;
      coh_state_e state;
      logic [tag_width-1:0] tag;
    } tag_info;
  } lce_cmd_payload_u;

  // block address interleaved across the directories
  function automatic logic [cce_id_width-1:0] cce_id_of(
    input logic [paddr_width-1:0] addr,
    input int unsigned num_cce
  );
    logic [paddr_width-1:0] block_addr;
    block_addr = addr >> block_offset_width;
    return cce_id_width'(block_addr % num_cce);
  endfunction

endpackage
